// File: Bender.yml
package:
  name: host_tx

sources:
  - logic/host_tx_pkg.sv
  - logic/word_cache.sv
  - logic/residence_clock.sv
  - logic/frame_serializer.sv
  - logic/host_tx_top.sv
  - target: test
    files:
      - test/host_tx_tb.sv

// File: host_tx_top.f
logic/host_tx_pkg.sv
logic/word_cache.sv
logic/residence_clock.sv
logic/frame_serializer.sv
logic/host_tx_top.sv
test/host_tx_tb.sv

// File: logic/frame_serializer.sv
/*
 * frame serializer of the host transmit port
 * sends preamble and SFD, then the cached words one byte per cycle,
 * puts the corrected field into PTP event frames and holds the gap
 */

`timescale 1ns/1ps
`default_nettype none

module frame_serializer (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst_n,
    input  wire logic [host_tx_pkg::WORD_W-1:0]  i_head_word,
    input  wire logic                            i_head_valid,
    input  wire logic [host_tx_pkg::CORR_W-1:0]  i_corr_out,
    output logic                                 o_pop,
    output logic      [host_tx_pkg::STAMP_W-1:0] o_stamp,
    output logic      [host_tx_pkg::CORR_W-1:0]  o_corr_in,
    output logic      [7:0]                      o_data,
    output logic                                 o_data_wr,
    output logic                                 o_frame_start
);

    import host_tx_pkg::*;

    logic [ST_W-1:0]       state_q;
    logic [BYTE_IDX_W-1:0] byte_idx_q;
    logic [GAP_CNT_W-1:0]  gap_cnt_q;
    logic                  is_ptp_q;
    logic                  first_word_q;
    logic [CORR_W-1:0]     corr_q;
    pkt_data_u             head_data;
    pkt_data_u             tx_data;
    logic                  head_is_start;
    logic                  head_is_tail;
    logic                  head_is_ptp;
    logic [BYTE_IDX_W-1:0] last_idx;
    logic                  in_payload;
    logic                  word_done;
    logic [7:0]            tx_byte;

    // ****************************************
    // head word decode
    // ****************************************
    assign head_data     = i_head_word[DATA_W-1:0];
    assign head_is_start = i_head_valid && (i_head_word[WORD_W-1 -: 2] == POS_HEAD);
    assign head_is_tail  = (i_head_word[WORD_W-1 -: 2] == POS_TAIL);

    // sync, pdelay_req and pdelay_resp carry a residence correction
    assign head_is_ptp = (head_data.eth_view.eth_type == ETH_PTP) &&
                         ((head_data.eth_view.msg_type == PTP_MSG_SYNC) ||
                          (head_data.eth_view.msg_type == PTP_MSG_PDELAY_REQ) ||
                          (head_data.eth_view.msg_type == PTP_MSG_PDELAY_RESP));

    // a tail word stops short by its empty count
    assign last_idx = head_is_tail ?
                      {BYTE_IDX_W{1'b1}} - i_head_word[DATA_W +: EMPTY_W] :
                      {BYTE_IDX_W{1'b1}};

    assign in_payload = (state_q == ST_WORD) || (state_q == ST_PTP2);
    assign word_done  = in_payload && i_head_valid && (byte_idx_q == last_idx);
    assign o_pop      = word_done;

    // correction bytes of word 2 come from the latched field
    always_comb begin
        tx_data = head_data;
        if (state_q == ST_PTP2) begin
            tx_data.ptp_view.corr = corr_q;
        end
    end

    assign tx_byte   = tx_data[DATA_W - 1 - 8 * byte_idx_q -: 8];
    assign o_corr_in = head_data.ptp_view.corr;

    // ****************************************
    // stamp and correction capture
    // ****************************************
    always_ff @(posedge i_clk) begin
        if ((state_q == ST_IDLE) && head_is_start) begin
            o_stamp <= head_data.eth_view.dmac[STAMP_W-1:0];
        end
        // taken as the first byte of word 2 is registered
        if ((state_q == ST_PTP2) && i_head_valid && (byte_idx_q == '0)) begin
            corr_q <= i_corr_out;
        end
    end

    // ****************************************
    // transmit FSM
    // ****************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q       <= ST_IDLE;
            byte_idx_q    <= '0;
            gap_cnt_q     <= '0;
            is_ptp_q      <= 1'b0;
            first_word_q  <= 1'b0;
            o_data        <= '0;
            o_data_wr     <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            o_data        <= '0;
            o_data_wr     <= 1'b0;
            o_frame_start <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (head_is_start) begin
                        o_data        <= PREAMBLE_BYTE;
                        o_data_wr     <= 1'b1;
                        o_frame_start <= 1'b1;
                        byte_idx_q    <= BYTE_IDX_W'(1);
                        is_ptp_q      <= head_is_ptp;
                        first_word_q  <= 1'b1;
                        state_q       <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    o_data_wr <= 1'b1;
                    if (byte_idx_q == BYTE_IDX_W'(PREAMBLE_BYTES - 1)) begin
                        o_data     <= SFD_BYTE;
                        byte_idx_q <= '0;
                        state_q    <= ST_WORD;
                    end else begin
                        o_data     <= PREAMBLE_BYTE;
                        byte_idx_q <= byte_idx_q + 1'b1;
                    end
                end
                ST_WORD, ST_PTP2: begin
                    // no word cached yet, strobe stays low until it lands
                    if (i_head_valid) begin
                        o_data     <= tx_byte;
                        o_data_wr  <= 1'b1;
                        byte_idx_q <= byte_idx_q + 1'b1;
                        if (word_done) begin
                            byte_idx_q   <= '0;
                            first_word_q <= 1'b0;
                            if (head_is_tail) begin
                                state_q <= ST_GAP;
                            end else if (first_word_q && is_ptp_q) begin
                                state_q <= ST_PTP2;
                            end else begin
                                state_q <= ST_WORD;
                            end
                        end
                    end
                end
                ST_GAP: begin
                    if (gap_cnt_q == GAP_CNT_W'(IFG_CYCLES - 1)) begin
                        gap_cnt_q <= '0;
                        state_q   <= ST_IDLE;
                    end else begin
                        gap_cnt_q <= gap_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // a new frame starts only after a full gap of quiet cycles
    a_gap_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_frame_start |-> !$past(o_data_wr, IFG_CYCLES));

endmodule

`default_nettype wire

// File: logic/host_tx_pkg.sv
/*
 * host port transmit path, shared definitions
 * cache word layout, ethernet and PTP field codes, the two views
 * of the payload and the timing constants of the byte serializer
 */

`default_nettype none

package host_tx_pkg;

    // ****************************************
    // cache word layout
    // ****************************************
    localparam int WORD_W  = 134;
    localparam int DATA_W  = 128;
    localparam int EMPTY_W = 4;
    localparam int TAG_W   = 48;

    // position code in the two top bits, anything else is a middle word
    localparam logic [1:0] POS_HEAD = 2'b01;
    localparam logic [1:0] POS_TAIL = 2'b10;

    // ethertypes and ptp event messages
    localparam logic [15:0] ETH_TSN_INNER = 16'h1800;
    localparam logic [15:0] ETH_IPV4      = 16'h0800;
    localparam logic [15:0] ETH_PTP       = 16'h88F7;

    localparam logic [3:0] PTP_MSG_SYNC        = 4'h1;
    localparam logic [3:0] PTP_MSG_PDELAY_REQ  = 4'h3;
    localparam logic [3:0] PTP_MSG_PDELAY_RESP = 4'h4;

    // residence time, local time base wraps every 4 ms
    localparam int STAMP_W     = 19;
    localparam int TIME_PERIOD = 500000;
    localparam int CORR_W      = 64;

    // ****************************************
    // cache and serializer sizing
    // ****************************************
    localparam int CACHE_DEPTH = 2;
    localparam int CACHE_PTR_W = $clog2(CACHE_DEPTH);
    localparam int CACHE_CNT_W = $clog2(CACHE_DEPTH + 1);
    localparam int BYTE_IDX_W  = $clog2(DATA_W / 8);

    localparam int         PREAMBLE_BYTES = 8;
    localparam logic [7:0] PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0] SFD_BYTE       = 8'hD5;
    localparam int         IFG_CYCLES     = 12;
    localparam int         GAP_CNT_W      = $clog2(IFG_CYCLES);

    // serializer states
    localparam int              ST_W        = 3;
    localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;
    localparam logic [ST_W-1:0] ST_PREAMBLE = 3'd1;
    localparam logic [ST_W-1:0] ST_WORD     = 3'd2;
    localparam logic [ST_W-1:0] ST_PTP2     = 3'd3;
    localparam logic [ST_W-1:0] ST_GAP      = 3'd4;

    // head word seen as ethernet header, second word as ptp body
    typedef union packed {
        struct packed {
            logic [TAG_W-1:0] dmac;
            logic [47:0]      smac;
            logic [15:0]      eth_type;
            logic [3:0]       rsvd_hi;
            logic [3:0]       msg_type;
            logic [7:0]       rsvd_lo;
        } eth_view;
        struct packed {
            logic [47:0]       lead;
            logic [CORR_W-1:0] corr;
            logic [15:0]       trail;
        } ptp_view;
    } pkt_data_u;

endpackage

`default_nettype wire

// File: logic/host_tx_top.sv
/*
 * host port transmit path, top level
 * word cache and residence clock side by side,
 * frame serializer driving the PHY byte stream
 */

`timescale 1ns/1ps
`default_nettype none

module host_tx_top (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic [host_tx_pkg::WORD_W-1:0] i_word,
    input  wire logic                           i_word_wr,
    input  wire logic [host_tx_pkg::TAG_W-1:0]  i_tsntag,
    input  wire logic                           i_dmac_replace,
    input  wire logic                           i_desc_wr,
    input  wire logic                           i_timer_rst,
    output logic                                o_word_credit,
    output logic                                o_tail_accepted,
    output logic                                o_frame_start,
    output logic      [7:0]                     o_data,
    output logic                                o_data_wr
);

    import host_tx_pkg::*;

    logic [WORD_W-1:0]  head_word;
    logic               head_valid;
    logic               pop;
    logic [STAMP_W-1:0] stamp;
    logic [CORR_W-1:0]  corr_in;
    logic [CORR_W-1:0]  corr_out;

    word_cache u_word_cache (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_word          (i_word),
        .i_word_wr       (i_word_wr),
        .i_tsntag        (i_tsntag),
        .i_dmac_replace  (i_dmac_replace),
        .i_desc_wr       (i_desc_wr),
        .i_pop           (pop),
        .o_head_word     (head_word),
        .o_head_valid    (head_valid),
        .o_word_credit   (o_word_credit),
        .o_tail_accepted (o_tail_accepted)
    );

    residence_clock u_residence_clock (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_timer_rst (i_timer_rst),
        .i_stamp     (stamp),
        .i_corr_in   (corr_in),
        .o_corr_out  (corr_out)
    );

    frame_serializer u_frame_serializer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_head_word   (head_word),
        .i_head_valid  (head_valid),
        .i_corr_out    (corr_out),
        .o_pop         (pop),
        .o_stamp       (stamp),
        .o_corr_in     (corr_in),
        .o_data        (o_data),
        .o_data_wr     (o_data_wr),
        .o_frame_start (o_frame_start)
    );

endmodule

`default_nettype wire

// File: logic/residence_clock.sv
/*
 * residence clock for PTP event messages
 * local time base wrapping every 4 ms and the correction
 * field plus the time spent since the receive stamp
 */

`timescale 1ns/1ps
`default_nettype none

module residence_clock (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst_n,
    input  wire logic                            i_timer_rst,
    input  wire logic [host_tx_pkg::STAMP_W-1:0] i_stamp,
    input  wire logic [host_tx_pkg::CORR_W-1:0]  i_corr_in,
    output logic      [host_tx_pkg::CORR_W-1:0]  o_corr_out
);

    import host_tx_pkg::*;

    logic [STAMP_W-1:0] time_q;
    logic [STAMP_W:0]   elapsed;

    // ****************************************
    // local time base
    // ****************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            time_q <= '0;
        end else if (i_timer_rst) begin
            time_q <= '0;
        end else if (time_q == STAMP_W'(TIME_PERIOD - 1)) begin
            time_q <= '0;
        end else begin
            time_q <= time_q + 1'b1;
        end
    end

    // stamp ahead of the clock means the base wrapped in between
    always_comb begin
        if (time_q >= i_stamp) begin
            elapsed = {1'b0, time_q} - {1'b0, i_stamp};
        end else begin
            elapsed = {1'b0, time_q} + (STAMP_W + 1)'(TIME_PERIOD) - {1'b0, i_stamp};
        end
    end

    assign o_corr_out = i_corr_in + CORR_W'(elapsed);

    a_time_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        time_q < STAMP_W'(TIME_PERIOD));

endmodule

`default_nettype wire

// File: logic/word_cache.sv
/*
 * word cache of the host transmit port
 * rewrites the head word on entry, holds words in a two-entry
 * in-order FIFO and returns one credit per word taken out
 */

`timescale 1ns/1ps
`default_nettype none

module word_cache (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic [host_tx_pkg::WORD_W-1:0] i_word,
    input  wire logic                           i_word_wr,
    input  wire logic [host_tx_pkg::TAG_W-1:0]  i_tsntag,
    input  wire logic                           i_dmac_replace,
    input  wire logic                           i_desc_wr,
    input  wire logic                           i_pop,
    output logic      [host_tx_pkg::WORD_W-1:0] o_head_word,
    output logic                                o_head_valid,
    output logic                                o_word_credit,
    output logic                                o_tail_accepted
);

    import host_tx_pkg::*;

    logic [TAG_W-1:0]       tag_q;
    logic                   replace_q;
    logic                   is_head;
    logic                   is_tail;
    pkt_data_u              in_data;
    logic [WORD_W-1:0]      wr_word;
    logic [WORD_W-1:0]      slot_q [CACHE_DEPTH];
    logic [CACHE_PTR_W-1:0] wr_ptr_q;
    logic [CACHE_PTR_W-1:0] rd_ptr_q;
    logic [CACHE_CNT_W-1:0] count_q;

    // ****************************************
    // descriptor
    // ****************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            replace_q <= 1'b0;
        end else if (i_desc_wr) begin
            replace_q <= i_dmac_replace;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_desc_wr) begin
            tag_q <= i_tsntag;
        end
    end

    // ****************************************
    // head word rewrite
    // ****************************************
    assign is_head = (i_word[WORD_W-1 -: 2] == POS_HEAD);
    assign is_tail = (i_word[WORD_W-1 -: 2] == POS_TAIL);

    always_comb begin
        in_data = i_word[DATA_W-1:0];
        if (is_head) begin
            // tsn tag takes the place of the destination mac
            if (replace_q) begin
                in_data.eth_view.dmac = tag_q;
            end
            if (in_data.eth_view.eth_type == ETH_TSN_INNER) begin
                in_data.eth_view.eth_type = ETH_IPV4;
            end
        end
    end

    assign wr_word = {i_word[WORD_W-1:DATA_W], in_data};

    // ****************************************
    // two-entry FIFO
    // ****************************************
    always_ff @(posedge i_clk) begin
        if (i_word_wr) begin
            slot_q[wr_ptr_q] <= wr_word;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (i_word_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (i_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CACHE_CNT_W'(i_word_wr) - CACHE_CNT_W'(i_pop);
        end
    end

    assign o_head_word  = slot_q[rd_ptr_q];
    assign o_head_valid = (count_q != '0);

    // credit back one cycle after the pop, tail pulse one cycle after the write
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_word_credit   <= 1'b0;
            o_tail_accepted <= 1'b0;
        end else begin
            o_word_credit   <= i_pop;
            o_tail_accepted <= i_word_wr && is_tail;
        end
    end

    // upstream only writes with credit in hand
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_word_wr |-> (count_q < CACHE_CNT_W'(CACHE_DEPTH)));

    // serializer only finishes words that are stored
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> o_head_valid);

endmodule

`default_nettype wire

// File: test/host_tx_tb.sv
/*
 * testbench of the host port transmit path
 * random frames through the credit interface, PHY bytes checked
 * against a reference of rewrite, PTP correction and tail trimming
 */

`timescale 1ns/1ps
`default_nettype none

module host_tx_tb;

    import host_tx_pkg::*;

    localparam int N_FRAMES  = 10;
    localparam int MAX_WORDS = 48;

    logic              i_clk;
    logic              i_rst_n;
    logic [WORD_W-1:0] i_word;
    logic              i_word_wr;
    logic [TAG_W-1:0]  i_tsntag;
    logic              i_dmac_replace;
    logic              i_desc_wr;
    logic              i_timer_rst;
    logic              o_word_credit;
    logic              o_tail_accepted;
    logic              o_frame_start;
    logic [7:0]        o_data;
    logic              o_data_wr;

    logic [WORD_W-1:0] words [MAX_WORDS];
    int                f_first [N_FRAMES];
    int                f_len [N_FRAMES];
    int                f_empty [N_FRAMES];
    logic [TAG_W-1:0]  f_tag [N_FRAMES];
    logic              f_repl [N_FRAMES];
    int                n_words = 0;
    logic [31:0]       rng;
    int                local_time;
    int                edge_time;
    int                cycles = 0;
    int                cycle_limit = 100000;
    int                value_errs = 0;
    int                other_errs = 0;
    int                n_bytes = 0;
    int                n_starts = 0;
    int                n_tails = 0;
    int                rx_frame = 0;
    int                rx_k = 0;
    int                idle_run = 0;
    int                ptp_time = 0;
    logic              in_frame = 1'b0;

    host_tx_top dut0 (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_word          (i_word),
        .i_word_wr       (i_word_wr),
        .i_tsntag        (i_tsntag),
        .i_dmac_replace  (i_dmac_replace),
        .i_desc_wr       (i_desc_wr),
        .i_timer_rst     (i_timer_rst),
        .o_word_credit   (o_word_credit),
        .o_tail_accepted (o_tail_accepted),
        .o_frame_start   (o_frame_start),
        .o_data          (o_data),
        .o_data_wr       (o_data_wr)
    );

    always #20 i_clk = ~i_clk;

    // ****************************************
    // helpers
    // ****************************************
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errs++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // kind 0 other ethertype, 1 inner TSN ethertype, 2 PTP
    task automatic make_frame(input int f, input int kind, input logic repl,
                              input logic [3:0] msg, input int stamp);
        logic [DATA_W-1:0] pl;
        logic [1:0]        pos;
        logic [31:0]       r;
        r          = xorshift32();
        f_len[f]   = (kind == 2) ? 3 + r % 2 : 2 + r % 3;
        f_first[f] = n_words;
        f_empty[f] = xorshift32() % 16;
        f_tag[f]   = TAG_W'({xorshift32(), xorshift32()});
        f_repl[f]  = repl;
        for (int w = 0; w < f_len[f]; w++) begin
            pl = {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
            if (w == 0) begin
                pos = POS_HEAD;
                if (kind == 0) begin
                    pl[31:16] = (pl[31:16] & 16'hFFF0) | 16'h0002;
                end else if (kind == 1) begin
                    pl[31:16] = 16'h1800;
                end else begin
                    pl[31:16] = 16'h88F7;
                    pl[11:8]  = msg;
                    pl[98:80] = STAMP_W'(stamp);
                end
            end else begin
                pos = (w == f_len[f] - 1) ? POS_TAIL : ((w % 2) ? 2'b11 : 2'b00);
            end
            words[n_words] = {pos, (pos == POS_TAIL) ? 4'(f_empty[f]) : 4'h0, pl};
            n_words++;
        end
    endtask

    function automatic int frame_bytes(input int f);
        return PREAMBLE_BYTES + 16 * f_len[f] - f_empty[f];
    endfunction

    // expected k-th strobed byte of frame f, t is the local time at the latch
    function automatic logic [7:0] ref_byte(input int f, input int k, input int t);
        logic [DATA_W-1:0] hd;
        logic [DATA_W-1:0] pl;
        int                p;
        int                stamp;
        if (k < 7) begin
            return 8'h55;
        end
        if (k == 7) begin
            return 8'hD5;
        end
        p  = k - 8;
        hd = words[f_first[f]][DATA_W-1:0];
        if (f_repl[f]) begin
            hd[127:80] = f_tag[f];
        end
        if (hd[31:16] == 16'h1800) begin
            hd[31:16] = 16'h0800;
        end
        pl = (p < 16) ? hd : words[f_first[f] + p / 16][DATA_W-1:0];
        if ((p / 16 == 1) && (hd[31:16] == 16'h88F7) &&
            ((hd[11:8] == 4'd1) || (hd[11:8] == 4'd3) || (hd[11:8] == 4'd4))) begin
            stamp     = hd[98:80];
            pl[79:16] = pl[79:16] + 64'((t >= stamp) ? t - stamp : t + 500000 - stamp);
        end
        return pl[DATA_W - 1 - 8 * (p % 16) -: 8];
    endfunction

    // ****************************************
    // local time mirror and timeout
    // ****************************************
    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            local_time <= 0;
            edge_time  <= 0;
        end else begin
            edge_time <= local_time;
            if (i_timer_rst || (local_time == TIME_PERIOD - 1)) begin
                local_time <= 0;
            end else begin
                local_time <= local_time + 1;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d frames seen",
                     cycles, rx_frame, N_FRAMES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ****************************************
    // byte stream compare
    // ****************************************
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (o_frame_start) begin
                n_starts++;
                if (in_frame || rx_frame >= N_FRAMES) begin
                    report_failure("frame start pulse not expected here");
                end else begin
                    if (rx_frame > 0 && idle_run < IFG_CYCLES) begin
                        report_failure($sformatf("gap of only %0d idle cycles", idle_run));
                    end
                    in_frame = 1'b1;
                end
            end
            if (o_data_wr) begin
                idle_run = 0;
                if (!in_frame) begin
                    report_failure("byte strobed outside a frame");
                end else begin
                    // word 2 begins, corrected field was latched at this edge
                    if (rx_k == PREAMBLE_BYTES + 16) begin
                        ptp_time = edge_time;
                    end
                    check_value("o_data", o_data, ref_byte(rx_frame, rx_k, ptp_time));
                    n_bytes++;
                    rx_k++;
                    if (rx_k == frame_bytes(rx_frame)) begin
                        in_frame = 1'b0;
                        rx_k     = 0;
                        rx_frame++;
                    end
                end
            end else begin
                idle_run++;
                if (in_frame) begin
                    report_failure("o_data_wr dropped inside a frame");
                end
            end
            if (o_tail_accepted) begin
                n_tails++;
            end
        end
    end

    // ****************************************
    // stimulus
    // ****************************************
    initial begin
        int          credits;
        int          returned;
        int          wr_idx;
        int          tx_frame;
        int          kind;
        logic        desc_sent;
        logic        tail_sent;
        logic [31:0] r;
        i_clk          = 1'b0;
        i_rst_n        = 1'b0;
        i_word         = '0;
        i_word_wr      = 1'b0;
        i_tsntag       = '0;
        i_dmac_replace = 1'b0;
        i_desc_wr      = 1'b0;
        i_timer_rst    = 1'b0;
        rng            = 32'd25203;

        make_frame(0, 0, 1'b0, 4'h0, 0);
        make_frame(1, 1, 1'b1, 4'h0, 0);
        make_frame(2, 0, 1'b1, 4'h0, 0);
        make_frame(3, 2, 1'b0, PTP_MSG_SYNC, 5);
        make_frame(4, 2, 1'b0, PTP_MSG_PDELAY_REQ, 400000);
        make_frame(5, 2, 1'b0, 4'h2, 1000);
        make_frame(6, 2, 1'b0, PTP_MSG_PDELAY_RESP, xorshift32() % TIME_PERIOD);
        for (int f = 7; f < N_FRAMES; f++) begin
            r    = xorshift32();
            kind = r % 3;
            make_frame(f, kind, (kind != 2) && r[8], PTP_MSG_SYNC, r % TIME_PERIOD);
        end
        cycle_limit = 40 + n_words * 16 + N_FRAMES * (PREAMBLE_BYTES + IFG_CYCLES + 8);

        repeat (16) @(negedge i_clk);
        check_value("o_data_wr", o_data_wr, 0);
        check_value("o_frame_start", o_frame_start, 0);
        check_value("o_tail_accepted", o_tail_accepted, 0);
        check_value("o_word_credit", o_word_credit, 0);
        check_value("o_data", o_data, 0);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        i_timer_rst = 1'b1;
        @(negedge i_clk);
        i_timer_rst = 1'b0;

        credits   = CACHE_DEPTH;
        returned  = 0;
        wr_idx    = 0;
        tx_frame  = 0;
        desc_sent = 1'b0;
        tail_sent = 1'b0;
        while (wr_idx < n_words || credits < CACHE_DEPTH) begin
            @(negedge i_clk);
            // a tail word written one cycle ago is acknowledged now
            check_value("o_tail_accepted", o_tail_accepted, tail_sent);
            tail_sent = 1'b0;
            i_word_wr = 1'b0;
            i_desc_wr = 1'b0;
            if (o_word_credit) begin
                credits++;
                returned++;
                if (credits > CACHE_DEPTH) begin
                    report_failure("credit returned beyond the cache depth");
                end
            end
            if (wr_idx < n_words) begin
                if (tx_frame < N_FRAMES && wr_idx == f_first[tx_frame] && !desc_sent) begin
                    i_tsntag       = f_tag[tx_frame];
                    i_dmac_replace = f_repl[tx_frame];
                    i_desc_wr      = 1'b1;
                    desc_sent      = 1'b1;
                end else if (credits > 0) begin
                    i_word    = words[wr_idx];
                    i_word_wr = 1'b1;
                    tail_sent = (words[wr_idx][WORD_W-1 -: 2] == POS_TAIL);
                    credits--;
                    if (tx_frame < N_FRAMES && wr_idx == f_first[tx_frame]) begin
                        tx_frame++;
                        desc_sent = 1'b0;
                    end
                    wr_idx++;
                end
            end
        end

        while (rx_frame < N_FRAMES) begin
            @(negedge i_clk);
        end
        repeat (IFG_CYCLES + 4) @(negedge i_clk);
        check_value("frame start count", n_starts, N_FRAMES);
        check_value("tail pulse count", n_tails, N_FRAMES);
        check_value("credits returned", returned, n_words);

        $display("%0d bytes checked, %0d value errors, %0d other errors",
                 n_bytes, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
